// ==== filelist.f ====
verilog/kvs_net_pkg.sv
verilog/stream_fifo.sv
verilog/listen_port_opener.sv
verilog/tx_meta_builder.sv
verilog/kvs_net_wrapper.sv
verif/tb_clock_gen.sv
verif/kvs_net_wrapper_tb.sv

// ==== Bender.yml ====
package:
  name: kvs_net_wrapper

sources:
  - target: rtl
    files:
      - verilog/kvs_net_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/listen_port_opener.sv
      - verilog/tx_meta_builder.sv
      - verilog/kvs_net_wrapper.sv
  - target: test
    files:
      - verilog/kvs_net_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/listen_port_opener.sv
      - verilog/tx_meta_builder.sv
      - verilog/kvs_net_wrapper.sv
      - verif/tb_clock_gen.sv
      - verif/kvs_net_wrapper_tb.sv

// ==== verif/kvs_net_wrapper_tb.sv ====
// testbench for kvs_net_wrapper: random stimulus, model queues, compare tasks, timeout
`timescale 1ns/1ps
`default_nettype none

module kvs_net_wrapper_tb import kvs_net_pkg::*;;

  localparam int    START_DELAY    = 40;
  localparam port_t FIRST_PORT     = DEFAULT_FIRST_PORT;
  localparam int    PORT_COUNT     = DEFAULT_PORT_COUNT;
  localparam int    MSG_COUNT      = 200;
  localparam int    MAX_BEATS      = 6;
  localparam int    TIMEOUT_CYCLES = START_DELAY + MSG_COUNT * MAX_BEATS * 8 + 2000;

  logic       aclk;
  logic       aresetn;
  logic       resp_valid;
  logic       resp_ready;
  resp_beat_t resp_beat;
  logic       tx_data_valid;
  logic       tx_data_ready;
  tx_beat_t   tx_data;
  logic       tx_meta_valid;
  logic       tx_meta_ready;
  tx_meta_t   tx_meta;
  logic       listen_port_valid;
  logic       listen_port_ready;
  port_t      listen_port;

  logic [31:0] lcg_state;
  tx_beat_t    exp_beats[$];
  tx_meta_t    exp_metas[$];
  int          meta_seen = 0;
  int          last_seen = 0;
  int          ports_seen = 0;
  int          reset_edges = 0;
  int          post_edges = 0;
  int          last_strobe_edge = -10;
  int          cycle_cnt = 0;

  tb_clock_gen tb_clock_gen_i (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  kvs_net_wrapper #(
    .START_DELAY (START_DELAY),
    .FIRST_PORT  (FIRST_PORT),
    .PORT_COUNT  (PORT_COUNT)
  ) kvs_net_wrapper_i (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .resp_valid        (resp_valid),
    .resp_ready        (resp_ready),
    .resp_beat         (resp_beat),
    .tx_data_valid     (tx_data_valid),
    .tx_data_ready     (tx_data_ready),
    .tx_data           (tx_data),
    .tx_meta_valid     (tx_meta_valid),
    .tx_meta_ready     (tx_meta_ready),
    .tx_meta           (tx_meta),
    .listen_port_valid (listen_port_valid),
    .listen_port_ready (listen_port_ready),
    .listen_port       (listen_port)
  );

  // ------------------------------
  // random numbers
  // ------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper half only, the low LCG bits have short periods
  function automatic int pick(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
  endfunction

  function automatic resp_beat_t make_beat(input logic last);
    resp_beat_t b;
    b.last = last;
    b.meta = {lcg_next(), lcg_next()};
    for (int w = 0; w < NET_DATA_W / 32; w++) begin
      b.data[w*32 +: 32] = lcg_next();
    end
    return b;
  endfunction

  // ------------------------------
  // error handling and compare tasks
  // ------------------------------

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("CHECK FAILED at %0t: %s is %b around reset, expected 0", $time, name, value);
      abort_run();
    end
  endtask

  task automatic check_tx_beat(input tx_beat_t got, input tx_beat_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: tx beat last %b data %h, expected last %b data %h",
               $time, got.last, got.data, exp.last, exp.data);
      abort_run();
    end
  endtask

  task automatic check_tx_meta(input tx_meta_t got, input tx_meta_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: tx meta len %0d session %h, expected len %0d session %h",
               $time, got.len, got.session, exp.len, exp.session);
      abort_run();
    end
  endtask

  task automatic check_port(input port_t got, input port_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: listen port %0d, expected %0d", $time, got, exp);
      abort_run();
    end
  endtask

  // expected outputs follow from the accepted input beat
  task automatic model_accept(input resp_beat_t b, input int beats,
                              input logic [SESSION_W-1:0] session);
    tx_beat_t eb;
    tx_meta_t em;
    eb.last = b.last;
    eb.data = b.data;
    exp_beats.push_back(eb);
    if (b.last) begin
      em.len     = TX_LEN_W'(BEAT_BYTES * beats);
      em.session = session;
      exp_metas.push_back(em);
    end
  endtask

  // ------------------------------
  // output monitor
  // ------------------------------

  always @(posedge aclk) begin
    if (!aresetn) begin
      if (reset_edges > 0) begin
        check_low("tx_data_valid", tx_data_valid);
        check_low("tx_meta_valid", tx_meta_valid);
        check_low("listen_port_valid", listen_port_valid);
      end
      reset_edges++;
    end else begin
      post_edges++;
      if (post_edges == 1) begin
        check_low("tx_data_valid", tx_data_valid);
        check_low("tx_meta_valid", tx_meta_valid);
        check_low("listen_port_valid", listen_port_valid);
      end
      if (listen_port_valid) begin
        if (ports_seen >= PORT_COUNT) begin
          $display("more listen strobes than ports at %0t", $time);
          abort_run();
        end else if (post_edges <= START_DELAY) begin
          $display("listen strobe at %0t came before the start-up delay ran out", $time);
          abort_run();
        end else if (post_edges == last_strobe_edge + 1) begin
          $display("listen strobes on adjacent cycles at %0t", $time);
          abort_run();
        end else begin
          check_port(listen_port, port_t'(FIRST_PORT + ports_seen));
          ports_seen++;
          last_strobe_edge = post_edges;
        end
      end
      if (tx_data_valid && tx_data_ready) begin
        if (exp_beats.size() == 0) begin
          $display("tx data beat at %0t with no beat expected", $time);
          abort_run();
        end else begin
          check_tx_beat(tx_data, exp_beats.pop_front());
          if (tx_data.last) begin
            last_seen++;
          end
        end
      end
      if (tx_meta_valid && tx_meta_ready) begin
        if (exp_metas.size() == 0) begin
          $display("tx meta word at %0t with no message finished", $time);
          abort_run();
        end else begin
          check_tx_meta(tx_meta, exp_metas.pop_front());
          meta_seen++;
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin : stimulus
    int                   msg_idx;
    int                   beat_idx;
    int                   beat_cnt;
    logic [SESSION_W-1:0] first_session;
    logic                 sent;
    logic                 done;
    resp_beat_t           next_beat;

    resp_valid        = 1'b0;
    resp_beat         = '0;
    tx_data_ready     = 1'b0;
    tx_meta_ready     = 1'b0;
    listen_port_ready = 1'b0;
    lcg_state         = 32'hed7d;
    msg_idx           = 0;
    beat_idx          = 0;
    beat_cnt          = 1;
    first_session     = '0;
    done              = 1'b0;

    @(posedge aresetn);
    while (!done) begin
      @(posedge aclk);
      sent = resp_valid && resp_ready;
      if (sent) begin
        model_accept(resp_beat, beat_cnt, first_session);
        if (resp_beat.last) begin
          msg_idx++;
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      #1;
      tx_data_ready     = (pick(4) != 0);
      tx_meta_ready     = (pick(4) != 0);
      listen_port_ready = (pick(3) != 0);
      // a presented beat stays put until it is taken
      if (sent || !resp_valid) begin
        if (msg_idx < MSG_COUNT && pick(4) != 0) begin
          if (beat_idx == 0) begin
            beat_cnt = 1 + pick(MAX_BEATS);
          end
          next_beat = make_beat(beat_idx == beat_cnt - 1);
          if (beat_idx == 0) begin
            first_session = next_beat.meta[SESSION_W-1:0];
          end
          resp_beat  = next_beat;
          resp_valid = 1'b1;
        end else begin
          resp_valid = 1'b0;
        end
      end
      done = (msg_idx == MSG_COUNT) && (meta_seen == MSG_COUNT) &&
             (last_seen == MSG_COUNT) && (ports_seen == PORT_COUNT);
    end

    // idle tail, any stray transfer or strobe shows up here
    tx_data_ready     = 1'b1;
    tx_meta_ready     = 1'b1;
    listen_port_ready = 1'b1;
    repeat (50) @(posedge aclk);
    #1;

    if (exp_beats.size() != 0 || exp_metas.size() != 0 || meta_seen != MSG_COUNT ||
        last_seen != MSG_COUNT || ports_seen != PORT_COUNT) begin
      $display("end of run: %0d beats and %0d words left, %0d meta, %0d last, %0d ports",
               exp_beats.size(), exp_metas.size(), meta_seen, last_seen, ports_seen);
      $display("=== FAIL ===");
      $fatal(1, "run ended with missing or extra transfers");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// testbench clock of period 20 ns and active-low reset held for 16 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic aclk,
  output logic aresetn
);

  localparam int RESET_CYCLES = 16;

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // release 1 ns after an edge, like every other input
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    aresetn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/kvs_net_wrapper.sv ====
// top level: response fifo, tx metadata builder, tx data/meta fifos, listen-port opener
`timescale 1ns/1ps
`default_nettype none

module kvs_net_wrapper import kvs_net_pkg::*; #(
  parameter int    START_DELAY = 200_000_000,
  parameter port_t FIRST_PORT  = DEFAULT_FIRST_PORT,
  parameter int    PORT_COUNT  = DEFAULT_PORT_COUNT
) (
  input  logic       aclk,
  input  logic       aresetn,

  input  logic       resp_valid,
  output logic       resp_ready,
  input  resp_beat_t resp_beat,

  output logic       tx_data_valid,
  input  logic       tx_data_ready,
  output tx_beat_t   tx_data,

  output logic       tx_meta_valid,
  input  logic       tx_meta_ready,
  output tx_meta_t   tx_meta,

  output logic       listen_port_valid,
  input  logic       listen_port_ready,
  output port_t      listen_port
);

  // data fifo is deep enough to absorb whole responses
  localparam int RESP_FIFO_LOG2 = 6;
  localparam int DATA_FIFO_LOG2 = 11;
  localparam int META_FIFO_LOG2 = 4;

  logic       resp_q_valid;
  logic       resp_q_ready;
  resp_beat_t resp_q_beat;

  logic       tx_beat_valid;
  logic       tx_beat_ready;
  tx_beat_t   tx_beat;

  logic       tx_word_valid;
  logic       tx_word_ready;
  tx_meta_t   tx_word;

  // ------------------------------
  // response path
  // ------------------------------

  stream_fifo #(
    .payload_t  (resp_beat_t),
    .DEPTH_LOG2 (RESP_FIFO_LOG2)
  ) resp_fifo_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (resp_valid),
    .in_ready  (resp_ready),
    .in_data   (resp_beat),
    .out_valid (resp_q_valid),
    .out_ready (resp_q_ready),
    .out_data  (resp_q_beat)
  );

  tx_meta_builder tx_meta_builder_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .in_valid   (resp_q_valid),
    .in_ready   (resp_q_ready),
    .in_beat    (resp_q_beat),
    .beat_valid (tx_beat_valid),
    .beat_ready (tx_beat_ready),
    .beat       (tx_beat),
    .meta_valid (tx_word_valid),
    .meta_ready (tx_word_ready),
    .meta       (tx_word)
  );

  stream_fifo #(
    .payload_t  (tx_beat_t),
    .DEPTH_LOG2 (DATA_FIFO_LOG2)
  ) tx_data_fifo_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (tx_beat_valid),
    .in_ready  (tx_beat_ready),
    .in_data   (tx_beat),
    .out_valid (tx_data_valid),
    .out_ready (tx_data_ready),
    .out_data  (tx_data)
  );

  stream_fifo #(
    .payload_t  (tx_meta_t),
    .DEPTH_LOG2 (META_FIFO_LOG2)
  ) tx_meta_fifo_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (tx_word_valid),
    .in_ready  (tx_word_ready),
    .in_data   (tx_word),
    .out_valid (tx_meta_valid),
    .out_ready (tx_meta_ready),
    .out_data  (tx_meta)
  );

  // ------------------------------
  // server ports
  // ------------------------------

  listen_port_opener #(
    .START_DELAY (START_DELAY),
    .FIRST_PORT  (FIRST_PORT),
    .PORT_COUNT  (PORT_COUNT)
  ) listen_port_opener_i (
    .aclk              (aclk),
    .aresetn           (aresetn),
    .listen_port_ready (listen_port_ready),
    .listen_port_valid (listen_port_valid),
    .listen_port       (listen_port)
  );

endmodule

`default_nettype wire

// ==== verilog/tx_meta_builder.sv ====
// response beat forwarding with per-message session/length tracking and tx metadata
`timescale 1ns/1ps
`default_nettype none

module tx_meta_builder import kvs_net_pkg::*; (
  input  logic       aclk,
  input  logic       aresetn,

  input  logic       in_valid,
  output logic       in_ready,
  input  resp_beat_t in_beat,

  output logic       beat_valid,
  input  logic       beat_ready,
  output tx_beat_t   beat,

  output logic       meta_valid,
  input  logic       meta_ready,
  output tx_meta_t   meta
);

  logic                 first_beat;
  logic [SESSION_W-1:0] session_q;
  logic [TX_LEN_W-1:0]  len_q;

  logic                 meta_free;
  logic                 xfer;
  logic [SESSION_W-1:0] cur_session;
  logic [TX_LEN_W-1:0]  next_len;

  // ------------------------------
  // beat path
  // ------------------------------

  // a pending word that can't leave blocks the next message
  assign meta_free = !meta_valid || meta_ready;

  assign in_ready   = beat_ready && meta_free;
  assign beat_valid = in_valid && meta_free;
  assign beat.last  = in_beat.last;
  assign beat.data  = in_beat.data;

  assign xfer = in_valid && in_ready;

  // session comes from the first beat only
  assign cur_session = first_beat ? in_beat.meta[SESSION_W-1:0] : session_q;
  assign next_len    = first_beat ? TX_LEN_W'(BEAT_BYTES) : len_q + TX_LEN_W'(BEAT_BYTES);

  // ------------------------------
  // message tracking
  // ------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      first_beat <= 1'b1;
      meta_valid <= 1'b0;
    end else begin
      if (meta_valid && meta_ready) begin
        meta_valid <= 1'b0;
      end
      if (xfer) begin
        first_beat <= in_beat.last;
        // a last beat in the same cycle as the pop reloads the word
        if (in_beat.last) begin
          meta_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (xfer) begin
      session_q <= cur_session;
      len_q     <= next_len;
      if (in_beat.last) begin
        meta.len     <= next_len;
        meta.session <= cur_session;
      end
    end
  end

  a_meta_held: assert property (@(posedge aclk) disable iff (!aresetn)
    meta_valid && !meta_ready |=> meta_valid && $stable(meta));

endmodule

`default_nettype wire

// ==== verilog/listen_port_opener.sv ====
// start-up delay counter and one-strobe-per-port listen announcement
`timescale 1ns/1ps
`default_nettype none

module listen_port_opener import kvs_net_pkg::*; #(
  parameter int    START_DELAY = 200_000_000,
  parameter port_t FIRST_PORT  = DEFAULT_FIRST_PORT,
  parameter int    PORT_COUNT  = DEFAULT_PORT_COUNT
) (
  input  logic  aclk,
  input  logic  aresetn,

  input  logic  listen_port_ready,
  output logic  listen_port_valid,
  output port_t listen_port
);

  localparam int DELAY_W   = $clog2(START_DELAY + 2);
  localparam int CNT_W     = $clog2(PORT_COUNT + 1);
  localparam int LAST_PORT = FIRST_PORT + PORT_COUNT - 1;

  logic [DELAY_W-1:0] delay_cnt;
  logic               delay_done;
  logic [CNT_W-1:0]   sent_cnt;
  logic               fire;

  // counter saturates once the delay has passed
  assign delay_done = (delay_cnt == DELAY_W'(START_DELAY));

  // strobe only from a low cycle, so strobes never touch
  assign fire = delay_done && !listen_port_valid && listen_port_ready &&
                (sent_cnt != CNT_W'(PORT_COUNT));

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      delay_cnt         <= '0;
      sent_cnt          <= '0;
      listen_port_valid <= 1'b0;
    end else begin
      if (!delay_done) begin
        delay_cnt <= delay_cnt + 1'b1;
      end
      // plain one-cycle pulse, no handshake
      listen_port_valid <= fire;
      if (fire) begin
        sent_cnt <= sent_cnt + 1'b1;
      end
    end
  end

  // port number only matters while the strobe is up
  always_ff @(posedge aclk) begin
    if (fire) begin
      listen_port <= FIRST_PORT + port_t'(sent_cnt);
    end
  end

  a_port_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
    listen_port_valid |-> (listen_port >= FIRST_PORT) && (int'(listen_port) <= LAST_PORT));

endmodule

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
// show-ahead valid/ready fifo with registered head and a type-parameter payload
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH_LOG2 = 4
) (
  input  logic     aclk,
  input  logic     aresetn,

  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,

  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int DEPTH = 1 << DEPTH_LOG2;
  localparam logic [DEPTH_LOG2:0] FULL_COUNT = {1'b1, {DEPTH_LOG2{1'b0}}};

  payload_t mem [DEPTH];

  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // items held in mem, the head register not included
  logic [DEPTH_LOG2:0]   mem_count;

  logic push;
  logic pop_mem;

  assign in_ready = (mem_count != FULL_COUNT);
  assign push     = in_valid && in_ready;

  // refill the head when it is empty or leaving this cycle
  assign pop_mem = (mem_count != '0) && (!out_valid || out_ready);

  // ------------------------------
  // storage and head register
  // ------------------------------

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (pop_mem) begin
      out_data <= mem[rd_ptr];
    end
  end

  // ------------------------------
  // pointers, fill count, head valid
  // ------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      mem_count <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_mem) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, pop_mem})
        2'b10:   mem_count <= mem_count + 1'b1;
        2'b01:   mem_count <= mem_count - 1'b1;
        default: mem_count <= mem_count;
      endcase

      if (pop_mem) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // stalled head must not change under the consumer
  a_head_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== verilog/kvs_net_pkg.sv ====
// stream widths, listen-port defaults and packed beat/metadata types
`default_nettype none

package kvs_net_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // one network beat
  localparam int NET_DATA_W = 512;

  // metadata carried along with each response beat
  localparam int RESP_META_W = 64;

  // session id sits in the low bits of the beat metadata
  localparam int SESSION_W = 16;

  // tx length field, in bytes
  localparam int TX_LEN_W = 16;

  // every beat is counted as a full 64 byte word
  localparam int BEAT_BYTES = 64;

  // tcp port number
  localparam int PORT_W = 16;

  // ------------------------------
  // basic types
  // ------------------------------

  typedef logic [NET_DATA_W-1:0] net_word_t;

  typedef logic [PORT_W-1:0] port_t;

  // ------------------------------
  // listen-port defaults
  // ------------------------------

  // server ports 2880 up to 2887
  localparam port_t DEFAULT_FIRST_PORT = 16'h0B40;

  localparam int DEFAULT_PORT_COUNT = 8;

  // ------------------------------
  // stream payloads
  // ------------------------------

  // response beat from the store, 577 bits
  typedef struct packed {
    logic                   last;
    logic [RESP_META_W-1:0] meta;
    net_word_t              data;
  } resp_beat_t;

  // beat towards the network, 513 bits
  typedef struct packed {
    logic      last;
    net_word_t data;
  } tx_beat_t;

  // tx metadata word, length above session
  typedef struct packed {
    logic [TX_LEN_W-1:0]  len;
    logic [SESSION_W-1:0] session;
  } tx_meta_t;

endpackage

`default_nettype wire
